// File: include/nn_defs.svh
// Network sizes, datapath widths and weight-map constants; include before nn_pkg and the RTL
`ifndef NN_DEFS_SVH
`define NN_DEFS_SVH

// --------------------
// Network shape
// --------------------
`define NN_LAYERS      2
`define NN_INPUTS      8
`define NN_L0_NEURONS  4
`define NN_L1_NEURONS  3

// Datapath widths
`define NN_ACT_W       8
`define NN_ACC_W       20
`define NN_SHIFT       4

// --------------------
// Weight store map
// --------------------
`define NN_WT_DEPTH    44
`define NN_WT_ADDR_W   6
`define NN_L0_BASE     0
// Layer 1 starts after the 8x4 block of layer 0
`define NN_L1_BASE     32

`endif

// File: logic/nn_pkg.sv
// Shared scalar types and stream / weight-port structs; compile before any module that imports it
`include "nn_defs.svh"

package nn_pkg;

  // Scalars
  typedef logic signed [`NN_ACT_W-1:0] act_t;
  typedef logic signed [`NN_ACT_W-1:0] weight_t;
  typedef logic signed [`NN_ACC_W-1:0] acc_t;
  typedef logic [`NN_WT_ADDR_W-1:0]    wt_addr_t;

  // One beat of the activation stream
  typedef struct packed {
    act_t data;
    logic last;
  } nn_beat_t;

  // Weight read port, one word per cycle
  typedef struct packed {
    logic     valid;
    wt_addr_t addr;
  } wt_req_t;

  typedef struct packed {
    logic    valid;
    weight_t data;
  } wt_rsp_t;

endpackage

// File: logic/weight_store.sv
// Shared weight ROM; picks the lowest-numbered requesting layer and answers one cycle later
`timescale 1ns/100ps
`include "nn_defs.svh"

module weight_store
  import nn_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wt_req_t req [`NN_LAYERS],
  output wt_rsp_t rsp [`NN_LAYERS]
);

  weight_t                mem [`NN_WT_DEPTH];
  logic [`NN_LAYERS-1:0]  req_vld;
  logic [`NN_LAYERS-1:0]  grant;
  logic [`NN_LAYERS-1:0]  rsp_grant;
  wt_addr_t               sel_addr;
  weight_t                rd_data;

  // Contents fixed at elaboration
  initial begin
    $readmemh("weights.hex", mem);
  end

  // Fixed priority, layer 0 highest
  always_comb begin
    grant    = '0;
    sel_addr = '0;
    for (int k = `NN_LAYERS - 1; k >= 0; k--) begin
      req_vld[k] = req[k].valid;
      if (req[k].valid) begin
        grant    = '0;
        grant[k] = 1'b1;
        sel_addr = req[k].addr;
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[sel_addr];
    if (rst) begin
      rsp_grant <= '0;
    end else begin
      rsp_grant <= grant;
    end
  end

  // Data is broadcast, valid only to the granted layer
  for (genvar k = 0; k < `NN_LAYERS; k++) begin : g_rsp
    assign rsp[k] = '{valid: rsp_grant[k], data: rd_data};
  end

  // The sequencer loads one layer at a time
  a_single_loader: assert property (@(posedge clk) disable iff (rst) $onehot0(req_vld));

endmodule

// File: logic/load_sequencer.sv
// Start-up FSM: loads each layer's weights in order, then holds nn_ready until reset
`timescale 1ns/100ps
`include "nn_defs.svh"

module load_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_load,
  input  logic [`NN_LAYERS-1:0]  load_done,
  output logic [`NN_LAYERS-1:0]  load_start,
  output logic                   nn_ready
);

  localparam int CNT_W = (`NN_LAYERS > 1) ? $clog2(`NN_LAYERS) : 1;
  localparam logic [CNT_W-1:0] LAST_LAYER = CNT_W'(`NN_LAYERS - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOAD,
    S_ACTIVE
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] cnt;

  // --------------------
  // Sequencing
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      cnt        <= '0;
      load_start <= '0;
      nn_ready   <= 1'b0;
    end else begin
      // load_start is a single-cycle pulse
      load_start <= '0;
      case (state)
        S_IDLE: begin
          if (start_load) begin
            cnt           <= '0;
            load_start[0] <= 1'b1;
            state         <= S_LOAD;
          end
        end
        S_LOAD: begin
          if (load_done[cnt]) begin
            if (cnt == LAST_LAYER) begin
              nn_ready <= 1'b1;
              state    <= S_ACTIVE;
            end else begin
              cnt                   <= cnt + 1'b1;
              load_start[cnt + 1'b1] <= 1'b1;
            end
          end
        end
        // Stays here until reset
        S_ACTIVE: ;
        default: state <= S_IDLE;
      endcase
    end
  end

  // A done pulse must come from the layer currently loading
  a_done_from_started: assert property (@(posedge clk) disable iff (rst)
    |load_done |-> (state == S_LOAD) && $onehot(load_done) && load_done[cnt]);

endmodule

// File: logic/mac_unit.sv
// Signed multiply-accumulate with ReLU, right shift and byte saturation on the result
`timescale 1ns/100ps
`include "nn_defs.svh"

module mac_unit
  import nn_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    clear,
  input  logic    en,
  input  act_t    a,
  input  weight_t w,
  output act_t    result
);

  // Largest positive activation, 127 for a byte
  localparam acc_t ACT_MAX = acc_t'((1 << (`NN_ACT_W - 1)) - 1);

  acc_t acc;
  acc_t shifted;
  acc_t clipped;

  // --------------------
  // Accumulator
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
    end else if (clear) begin
      acc <= '0;
    end else if (en) begin
      // Product is 16 bits, sign extended into the accumulator
      acc <= acc + a * w;
    end
  end

  // --------------------
  // Requantize
  // --------------------
  always_comb begin
    shifted = acc >>> `NN_SHIFT;
    if (acc < 0) begin
      // ReLU
      clipped = '0;
    end else if (shifted > ACT_MAX) begin
      clipped = ACT_MAX;
    end else begin
      clipped = shifted;
    end
    result = act_t'(clipped);
  end

endmodule

// File: logic/layer_core.sv
// One fully connected layer: loads its weights, buffers a vector, streams out one neuron at a time
`timescale 1ns/100ps
`include "nn_defs.svh"

module layer_core
  import nn_pkg::*;
#(
  parameter int N_IN  = 8,
  parameter int N_OUT = 4,
  parameter int BASE  = 0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     load_start,
  output logic     load_done,
  output wt_req_t  wt_req,
  input  wt_rsp_t  wt_rsp,
  input  nn_beat_t rx,
  input  logic     rx_valid,
  output logic     rx_ready,
  output nn_beat_t tx,
  output logic     tx_valid,
  input  logic     tx_ready
);

  localparam int N_WT  = N_IN * N_OUT;
  localparam int WT_W  = (N_WT > 1) ? $clog2(N_WT) : 1;
  localparam int IN_W  = (N_IN > 1) ? $clog2(N_IN) : 1;
  localparam int OUT_W = (N_OUT > 1) ? $clog2(N_OUT) : 1;

  localparam logic [WT_W-1:0]  WT_LAST  = WT_W'(N_WT - 1);
  localparam logic [IN_W-1:0]  IN_LAST  = IN_W'(N_IN - 1);
  localparam logic [OUT_W-1:0] OUT_LAST = OUT_W'(N_OUT - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD,
    S_RECV,
    S_CLEAR,
    S_MAC,
    S_SEND
  } state_t;

  state_t           state;
  weight_t          wbuf [N_WT];
  act_t             ibuf [N_IN];
  logic [WT_W-1:0]  req_cnt;
  logic [WT_W-1:0]  rsp_cnt;
  logic             req_done;
  // Weight pointer runs straight through the neuron-major buffer
  logic [WT_W-1:0]  w_idx;
  // Input slot, shared by capture and MAC phases
  logic [IN_W-1:0]  in_cnt;
  logic [OUT_W-1:0] out_cnt;
  act_t             mac_result;

  // --------------------
  // Ports
  // --------------------
  always_comb begin
    wt_req.valid = (state == S_LOAD) && !req_done;
    wt_req.addr  = wt_addr_t'(BASE) + wt_addr_t'(req_cnt);
    tx.data      = mac_result;
    tx.last      = (out_cnt == OUT_LAST);
  end

  assign rx_ready = (state == S_RECV);
  assign tx_valid = (state == S_SEND);

  mac_unit u_mac (
    .clk    (clk),
    .rst    (rst),
    .clear  (state == S_CLEAR),
    .en     (state == S_MAC),
    .a      (ibuf[in_cnt]),
    .w      (wbuf[w_idx]),
    .result (mac_result)
  );

  // Buffers
  always_ff @(posedge clk) begin
    if (state == S_LOAD && wt_rsp.valid) begin
      wbuf[rsp_cnt] <= wt_rsp.data;
    end
    if (rx_valid && rx_ready) begin
      ibuf[in_cnt] <= rx.data;
    end
  end

  // --------------------
  // Control FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      req_cnt   <= '0;
      rsp_cnt   <= '0;
      req_done  <= 1'b0;
      w_idx     <= '0;
      in_cnt    <= '0;
      out_cnt   <= '0;
      load_done <= 1'b0;
    end else begin
      load_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (load_start) begin
            req_cnt  <= '0;
            rsp_cnt  <= '0;
            req_done <= 1'b0;
            state    <= S_LOAD;
          end
        end
        S_LOAD: begin
          if (!req_done) begin
            req_cnt  <= req_cnt + 1'b1;
            req_done <= (req_cnt == WT_LAST);
          end
          if (wt_rsp.valid) begin
            rsp_cnt <= rsp_cnt + 1'b1;
            if (rsp_cnt == WT_LAST) begin
              load_done <= 1'b1;
              w_idx     <= '0;
              in_cnt    <= '0;
              out_cnt   <= '0;
              state     <= S_RECV;
            end
          end
        end
        S_RECV: begin
          if (rx_valid) begin
            in_cnt <= (in_cnt == IN_LAST) ? '0 : in_cnt + 1'b1;
            if (in_cnt == IN_LAST) begin
              state <= S_CLEAR;
            end
          end
        end
        S_CLEAR: state <= S_MAC;
        S_MAC: begin
          w_idx  <= (w_idx == WT_LAST) ? '0 : w_idx + 1'b1;
          in_cnt <= (in_cnt == IN_LAST) ? '0 : in_cnt + 1'b1;
          if (in_cnt == IN_LAST) begin
            state <= S_SEND;
          end
        end
        S_SEND: begin
          if (tx_ready) begin
            out_cnt <= (out_cnt == OUT_LAST) ? '0 : out_cnt + 1'b1;
            state   <= (out_cnt == OUT_LAST) ? S_RECV : S_CLEAR;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Upstream framing must agree with this layer's input count
  a_rx_last_framing: assert property (@(posedge clk) disable iff (rst)
    (rx_valid && rx_ready) |-> (rx.last == (in_cnt == IN_LAST)));

endmodule

// File: logic/nn_top.sv
// Two-layer inference pipeline top; connects load sequencer, weight store and the layer chain
`timescale 1ns/100ps
`include "nn_defs.svh"

module nn_top
  import nn_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  nn_beat_t rx,
  input  logic     rx_valid,
  output logic     rx_ready,
  output nn_beat_t tx,
  output logic     tx_valid,
  input  logic     tx_ready,
  input  logic     start_load,
  output logic     nn_ready
);

  logic [`NN_LAYERS-1:0] load_start;
  logic [`NN_LAYERS-1:0] load_done;
  wt_req_t               wt_req [`NN_LAYERS];
  wt_rsp_t               wt_rsp [`NN_LAYERS];

  // Hidden activations between the layers
  nn_beat_t              hid;
  logic                  hid_valid;
  logic                  hid_ready;

  // Input stream seen by layer 0
  logic                  l0_rx_valid;
  logic                  l0_rx_ready;

  // No input is taken until every layer holds its weights
  assign l0_rx_valid = rx_valid && nn_ready;
  assign rx_ready    = l0_rx_ready && nn_ready;

  // --------------------
  // Control and memory
  // --------------------
  load_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .start_load (start_load),
    .load_done  (load_done),
    .load_start (load_start),
    .nn_ready   (nn_ready)
  );

  weight_store u_store (
    .clk (clk),
    .rst (rst),
    .req (wt_req),
    .rsp (wt_rsp)
  );

  // --------------------
  // Layer chain
  // --------------------
  layer_core #(
    .N_IN  (`NN_INPUTS),
    .N_OUT (`NN_L0_NEURONS),
    .BASE  (`NN_L0_BASE)
  ) u_layer0 (
    .clk        (clk),
    .rst        (rst),
    .load_start (load_start[0]),
    .load_done  (load_done[0]),
    .wt_req     (wt_req[0]),
    .wt_rsp     (wt_rsp[0]),
    .rx         (rx),
    .rx_valid   (l0_rx_valid),
    .rx_ready   (l0_rx_ready),
    .tx         (hid),
    .tx_valid   (hid_valid),
    .tx_ready   (hid_ready)
  );

  // Output layer drives the top-level stream
  layer_core #(
    .N_IN  (`NN_L0_NEURONS),
    .N_OUT (`NN_L1_NEURONS),
    .BASE  (`NN_L1_BASE)
  ) u_layer1 (
    .clk        (clk),
    .rst        (rst),
    .load_start (load_start[1]),
    .load_done  (load_done[1]),
    .wt_req     (wt_req[1]),
    .wt_rsp     (wt_rsp[1]),
    .rx         (hid),
    .rx_valid   (hid_valid),
    .rx_ready   (hid_ready),
    .tx         (tx),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready)
  );

endmodule

// File: testbench/tb_clock.sv
// Testbench clock and synchronous reset source; reset released on a falling edge
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: testbench/tb_nn_top.sv
// Self-checking testbench for nn_top: table of input vectors, reference model and stream checks
`timescale 1ns/100ps
`include "nn_defs.svh"

module tb_nn_top
  import nn_pkg::*;
();

  localparam int CLK_PERIOD    = 20;
  localparam int NUM_FIXED     = 5;
  localparam int NUM_RANDOM    = 20;
  localparam int NUM_VEC       = NUM_FIXED + NUM_RANDOM;
  localparam int NUM_PASSES    = 2;
  // Loose cycle bounds for one load and one vector through both layers
  localparam int LOAD_BOUND    = `NN_WT_DEPTH + 4 * `NN_LAYERS;
  localparam int COMPUTE_BOUND = `NN_INPUTS + `NN_L0_NEURONS * (`NN_INPUTS + 2) +
                                 `NN_L1_NEURONS * (`NN_L0_NEURONS + 2);
  localparam int WATCHDOG_CYCLES = NUM_PASSES * NUM_VEC * (LOAD_BOUND + COMPUTE_BOUND) * 4;

  logic     clk;
  logic     rst;
  nn_beat_t rx;
  logic     rx_valid;
  logic     rx_ready;
  nn_beat_t tx;
  logic     tx_valid;
  logic     tx_ready;
  logic     start_load;
  logic     nn_ready;

  weight_t  wmem [`NN_WT_DEPTH];
  act_t     stim [NUM_VEC][`NN_INPUTS];
  act_t     expected_out [NUM_VEC][`NN_L1_NEURONS];
  integer   seed = 2;
  int       checks = 0;
  int       mismatches = 0;
  logic     ready_seen = 1'b0;

  tb_clock #(.PERIOD(CLK_PERIOD), .RST_CYCLES(10)) u_clock (.clk(clk), .rst(rst));

  nn_top dut (
    .clk        (clk),
    .rst        (rst),
    .rx         (rx),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .tx         (tx),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .start_load (start_load),
    .nn_ready   (nn_ready)
  );

  // --------------------
  // Reference model
  // --------------------
  function automatic act_t requantize(input acc_t acc);
    acc_t scaled;
    scaled = acc >>> `NN_SHIFT;
    if (acc < 0) return '0;
    if (scaled > acc_t'(127)) return act_t'(127);
    return act_t'(scaled);
  endfunction

  // Neuron-major: weight of neuron n for input i at base + n * n_in + i
  function automatic act_t neuron(input int base, input int n_in, input int n,
                                  input act_t x [`NN_INPUTS]);
    acc_t acc;
    int   prod;
    acc = '0;
    for (int i = 0; i < n_in; i++) begin
      prod = int'(x[i]) * int'(wmem[base + n * n_in + i]);
      acc  = acc + acc_t'(prod);
    end
    return requantize(acc);
  endfunction

  function automatic void build_table();
    act_t x   [`NN_INPUTS];
    act_t hid [`NN_INPUTS];
    for (int v = 0; v < NUM_VEC; v++) begin
      for (int i = 0; i < `NN_INPUTS; i++) begin
        case (v)
          0:       x[i] = '0;
          1:       x[i] = act_t'(127);
          2:       x[i] = act_t'(-128);
          3:       x[i] = (i % 2 == 0) ? act_t'(64) : act_t'(-64);
          4:       x[i] = (i == 5) ? act_t'(64) : act_t'(0);
          default: x[i] = act_t'($random(seed));
        endcase
        stim[v][i] = x[i];
        hid[i]     = '0;
      end
      for (int n = 0; n < `NN_L0_NEURONS; n++) begin
        hid[n] = neuron(`NN_L0_BASE, `NN_INPUTS, n, x);
      end
      for (int k = 0; k < `NN_L1_NEURONS; k++) begin
        expected_out[v][k] = neuron(`NN_L1_BASE, `NN_L0_NEURONS, k, hid);
      end
    end
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_act(input string name, input act_t got, input act_t want);
    checks++;
    if (got !== want) begin
      mismatches++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      mismatches++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
    end
  endtask

  // --------------------
  // Stream drivers
  // --------------------
  task automatic send_all();
    for (int v = 0; v < NUM_VEC; v++) begin
      for (int i = 0; i < `NN_INPUTS; i++) begin
        @(negedge clk);
        rx.data  = stim[v][i];
        rx.last  = (i == `NN_INPUTS - 1);
        rx_valid = 1'b1;
        // Beat goes on the next rising edge once ready is seen
        while (!rx_ready) @(negedge clk);
      end
    end
    @(negedge clk);
    rx_valid = 1'b0;
    rx       = '0;
  endtask

  task automatic receive_all(input bit random_ready);
    int       v;
    int       k;
    logic     held;
    nn_beat_t held_beat;
    integer   rnd;
    v         = 0;
    k         = 0;
    held      = 1'b0;
    held_beat = '0;
    while (v < NUM_VEC) begin
      @(negedge clk);
      check_flag("nn_ready", nn_ready, 1'b1);
      if (held) begin
        // Stalled beat must not move
        check_flag("tx_valid held", tx_valid, 1'b1);
        check_act("tx.data held", tx.data, held_beat.data);
        check_flag("tx.last held", tx.last, held_beat.last);
      end
      if (random_ready) begin
        rnd      = $random(seed);
        tx_ready = rnd[0];
      end else begin
        tx_ready = 1'b1;
      end
      if (tx_valid && tx_ready) begin
        check_act($sformatf("tx.data vec %0d beat %0d", v, k), tx.data, expected_out[v][k]);
        check_flag($sformatf("tx.last vec %0d beat %0d", v, k), tx.last,
                   k == `NN_L1_NEURONS - 1);
        held = 1'b0;
        if (k == `NN_L1_NEURONS - 1) begin
          k = 0;
          v++;
        end else begin
          k++;
        end
      end else begin
        held      = tx_valid;
        held_beat = tx;
      end
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rx         = '0;
    rx_valid   = 1'b0;
    tx_ready   = 1'b0;
    start_load = 1'b0;
    $readmemh("weights.hex", wmem);
    build_table();

    @(negedge rst);
    @(negedge clk);
    check_flag("nn_ready", nn_ready, 1'b0);
    check_flag("rx_ready", rx_ready, 1'b0);
    check_flag("tx_valid", tx_valid, 1'b0);
    // Nothing loaded yet, so no input may be accepted
    repeat (5) begin
      @(negedge clk);
      check_flag("rx_ready", rx_ready, 1'b0);
      check_flag("nn_ready", nn_ready, 1'b0);
    end

    start_load = 1'b1;
    @(negedge clk);
    start_load = 1'b0;
    // Input stays closed while any layer is still loading
    while (!nn_ready) begin
      check_flag("rx_ready", rx_ready, 1'b0);
      @(negedge clk);
    end
    ready_seen = 1'b1;
    check_flag("rx_ready", rx_ready, 1'b1);

    // First pass with the sink always ready, second with random back-pressure
    for (int p = 0; p < NUM_PASSES; p++) begin
      fork
        send_all();
        receive_all(p == 1);
      join
    end

    repeat (2) @(negedge clk);
    check_flag("tx_valid", tx_valid, 1'b0);
    check_flag("nn_ready", nn_ready, 1'b1);

    $display("checks %0d, mismatches %0d, timeouts 0", checks, mismatches);
    if (mismatches == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    if (!ready_seen) begin
      $display("error: nn_ready never rose after start_load");
    end else begin
      $display("error: output stream did not deliver all results in time");
    end
    $display("checks %0d, mismatches %0d, timeouts 1", checks, mismatches);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: nn_layers.f
+incdir+include
logic/nn_pkg.sv
logic/weight_store.sv
logic/load_sequencer.sv
logic/mac_unit.sv
logic/layer_core.sv
logic/nn_top.sv
testbench/tb_clock.sv
testbench/tb_nn_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the nn_top testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f nn_layers.f --top-module tb_nn_top -o sim_nn

# The simulation status is ignored here, the log decides
./obj_dir/sim_nn > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

// File: weights.hex
// One signed weight byte per line: layer 0 (4 neurons x 8 inputs) then layer 1 (3 x 4), neuron-major
10
F0
08
F8
04
FC
02
FE
05
05
05
05
05
05
05
05
E0
10
F0
20
E8
18
F4
0C
7F
01
81
02
03
FD
40
C0
20
F0
10
08
F8
30
E0
18
0C
0C
0C
0C
